//--- list.f
hw/z80_pkg.sv
hw/z80_adder.sv
hw/z80_alu8.sv
hw/z80_alu16.sv
hw/z80_alu_stage.sv
hw/z80_alu_unit.sv
dv/z80_alu_unit_sva.sv
dv/tb_z80_alu_unit.sv

//--- Bender.yml
package:
  name: z80_alu_unit

sources:
  - files:
      - hw/z80_pkg.sv
      - hw/z80_adder.sv
      - hw/z80_alu8.sv
      - hw/z80_alu16.sv
      - hw/z80_alu_stage.sv
      - hw/z80_alu_unit.sv
  - target: test
    files:
      - dv/z80_alu_unit_sva.sv
      - dv/tb_z80_alu_unit.sv

//--- dv/tb_z80_alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_z80_alu_unit;

    localparam int CLK_PERIOD = 8;
    localparam int N_ARITH8   = 150;
    localparam int N_LOGIC8   = 100;
    localparam int N_ROT_EACH = 20;
    localparam int N_ARITH16  = 100;
    localparam int N_OTHER16  = 24;
    localparam int N_BURST    = 200;
    localparam int NUM_OPS    = N_ARITH8 + N_LOGIC8 + 8 * N_ROT_EACH + N_ARITH16
                              + N_OTHER16 + N_BURST + 8;
    // an op with its own flag load needs four cycles at most
    localparam int WATCHDOG_NS = (4 * NUM_OPS + 100) * CLK_PERIOD;
    localparam logic [7:0] KEEP_BITS = (8'h01 << z80_pkg::FLAG_5) | (8'h01 << z80_pkg::FLAG_3);

    typedef struct packed {
        z80_pkg::alu_func_e func;
        logic [15:0]        result;
        logic               write_en;
        logic [7:0]         f;
    } expect_t;

    logic              clk;
    logic              reset;
    logic              req_valid;
    logic              f_load;
    z80_pkg::alu_req_t req;
    logic [7:0]        f_load_value;
    logic              rsp_valid;
    z80_pkg::alu_rsp_t rsp;
    logic [7:0]        f;

    integer     seed;
    logic [7:0] model_f;    // F as the model sees it
    logic [7:0] loaded_f;   // last value written by f_load
    expect_t    exp_q[$];
    expect_t    exp_head;
    int         mismatch_errors;
    int         other_errors;
    int         checked;

    z80_alu_unit u_z80_alu_unit (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .f_load       (f_load),
        .req          (req),
        .f_load_value (f_load_value),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .f            (f)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        int v;
        v = $random(seed);
        return int'($unsigned(v) % n);
    endfunction

    function automatic logic [15:0] rand16();
        int v;
        v = $random(seed);
        return v[15:0];
    endfunction

    function automatic logic [7:0] rand8();
        int v;
        v = $random(seed);
        return v[7:0];
    endfunction

    // flags for logic ops and shifts with P/V set on even parity
    function automatic logic [7:0] logic_flags(input logic [7:0] r, input logic h,
                                               input logic c);
        logic [7:0] fl;
        fl = 8'h00;
        fl[z80_pkg::FLAG_S]  = r[7];
        fl[z80_pkg::FLAG_Z]  = (r == 8'h00);
        fl[z80_pkg::FLAG_H]  = h;
        fl[z80_pkg::FLAG_PV] = ($countones(r) % 2) == 0;
        fl[z80_pkg::FLAG_C]  = c;
        return fl;
    endfunction

    // a + b + c or a - b - c at 8 or 16 bits, C and H mean borrow on subtraction
    task automatic arith_model(input logic wide, input logic [15:0] a, input logic [15:0] b,
                               input logic c_in, input logic sub, output logic [15:0] r,
                               output logic [7:0] fl);
        int msb;
        int mask;
        int hmask;
        int full;
        int half;
        msb   = wide ? 15 : 7;
        mask  = wide ? 32'h0000_ffff : 32'h0000_00ff;
        hmask = wide ? 32'h0000_0fff : 32'h0000_000f;   // half carry from bit 11 or 3
        if (sub) begin
            full = (a & mask) - (b & mask) - c_in;
            half = (a & hmask) - (b & hmask) - c_in;
        end else begin
            full = (a & mask) + (b & mask) + c_in;
            half = (a & hmask) + (b & hmask) + c_in;
        end
        r  = full[15:0] & mask[15:0];
        fl = 8'h00;
        fl[z80_pkg::FLAG_S] = r[msb];
        fl[z80_pkg::FLAG_Z] = (r == 16'h0000);
        fl[z80_pkg::FLAG_H] = (half > hmask) || (half < 0);
        if (sub) begin
            fl[z80_pkg::FLAG_PV] = (a[msb] != b[msb]) && (r[msb] != a[msb]);
        end else begin
            fl[z80_pkg::FLAG_PV] = (a[msb] == b[msb]) && (r[msb] != a[msb]);
        end
        fl[z80_pkg::FLAG_N] = sub;
        fl[z80_pkg::FLAG_C] = (full > mask) || (full < 0);
    endtask

    task automatic shift_model(input z80_pkg::alu_func_e func, input logic [7:0] a,
                               input logic c_old, output logic [7:0] r, output logic c_out);
        case (func)
            z80_pkg::ALU_RLC: r = {a[6:0], a[7]};
            z80_pkg::ALU_RRC: r = {a[0], a[7:1]};
            z80_pkg::ALU_RL:  r = {a[6:0], c_old};
            z80_pkg::ALU_RR:  r = {c_old, a[7:1]};
            z80_pkg::ALU_SLA: r = {a[6:0], 1'b0};
            z80_pkg::ALU_SRA: r = {a[7], a[7:1]};
            z80_pkg::ALU_SLL: r = {a[6:0], 1'b1};
            default:          r = {1'b0, a[7:1]};   // srl
        endcase
        case (func)
            z80_pkg::ALU_RLC, z80_pkg::ALU_RL, z80_pkg::ALU_SLA, z80_pkg::ALU_SLL: c_out = a[7];
            default: c_out = a[0];
        endcase
    endtask

    task automatic model_req(input z80_pkg::alu_req_t r);
        expect_t     e;
        logic [15:0] res;
        logic        cin;
        logic        sub;
        logic [7:0]  res8;
        logic        c_out;
        logic [7:0]  fl;
        e.func     = r.func;
        e.result   = 16'h0000;
        e.write_en = (r.func != z80_pkg::ALU_CP);
        fl         = model_f;   // 16-bit logic and shifts leave F alone
        case (r.func)
            z80_pkg::ALU_ADD, z80_pkg::ALU_ADC, z80_pkg::ALU_SUB, z80_pkg::ALU_SBC,
            z80_pkg::ALU_CP: begin
                sub = (r.func == z80_pkg::ALU_SUB) || (r.func == z80_pkg::ALU_SBC)
                   || (r.func == z80_pkg::ALU_CP);
                case (r.func)
                    z80_pkg::ALU_ADC: cin = model_f[z80_pkg::FLAG_C];
                    z80_pkg::ALU_SBC: cin = model_f[z80_pkg::FLAG_C];  // x - y - c
                    default:          cin = 1'b0;
                endcase
                arith_model(r.wide, r.x, r.y, cin, sub, res, fl);
                e.result = res;
            end
            z80_pkg::ALU_AND, z80_pkg::ALU_XOR, z80_pkg::ALU_OR: begin
                if (!r.wide) begin
                    case (r.func)
                        z80_pkg::ALU_AND: res8 = r.x[7:0] & r.y[7:0];
                        z80_pkg::ALU_XOR: res8 = r.x[7:0] ^ r.y[7:0];
                        default:          res8 = r.x[7:0] | r.y[7:0];
                    endcase
                    e.result = {8'h00, res8};
                    fl = logic_flags(res8, r.func == z80_pkg::ALU_AND, 1'b0);
                end
            end
            default: begin
                if (!r.wide) begin
                    shift_model(r.func, r.x[7:0], model_f[z80_pkg::FLAG_C], res8, c_out);
                    e.result = {8'h00, res8};
                    fl = logic_flags(res8, 1'b0, c_out);
                end
            end
        endcase
        fl[z80_pkg::FLAG_5] = model_f[z80_pkg::FLAG_5];
        fl[z80_pkg::FLAG_3] = model_f[z80_pkg::FLAG_3];
        e.f     = fl;
        model_f = fl;
        exp_q.push_back(e);
    endtask

    task automatic idle(input int cycles);
        req_valid = 1'b0;
        f_load    = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    // waits for the pipeline to drain so the load never meets a flag update
    task automatic load_flags(input logic [7:0] value);
        idle(2);
        f_load       = 1'b1;
        f_load_value = value;
        model_f      = value;
        loaded_f     = value;
        @(negedge clk);
        f_load = 1'b0;
    endtask

    task automatic send_req(input z80_pkg::alu_func_e func, input logic wide,
                            input logic [15:0] x, input logic [15:0] y);
        z80_pkg::alu_req_t r;
        r.func    = func;
        r.wide    = wide;
        r.x       = x;
        r.y       = y;
        req       = r;
        req_valid = 1'b1;
        f_load    = 1'b0;
        model_req(r);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!reset && rsp_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("response arrived with no request outstanding at %0t", $time);
            end else begin
                exp_head = exp_q.pop_front();
                checked++;
                if (rsp.result !== exp_head.result) begin
                    mismatch_errors++;
                    $display("[FAIL] rsp.result: got %h expected %h (%s)", rsp.result,
                             exp_head.result, exp_head.func.name());
                end
                if (rsp.write_en !== exp_head.write_en) begin
                    mismatch_errors++;
                    $display("[FAIL] rsp.write_en: got %h expected %h (%s)", rsp.write_en,
                             exp_head.write_en, exp_head.func.name());
                end
                if (f !== exp_head.f) begin
                    mismatch_errors++;
                    $display("[FAIL] f: got %h expected %h (%s)", f, exp_head.f,
                             exp_head.func.name());
                end
                if ((f & KEEP_BITS) !== (loaded_f & KEEP_BITS)) begin
                    mismatch_errors++;
                    $display("[FAIL] f bits 5/3: got %h expected %h", f & KEEP_BITS,
                             loaded_f & KEEP_BITS);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int i;
        int k;
        int idx;
        seed            = 32'h9b624078;
        clk             = 1'b0;
        reset           = 1'b1;
        req_valid       = 1'b0;
        f_load          = 1'b0;
        req             = '0;
        f_load_value    = 8'h00;
        model_f         = 8'h00;
        loaded_f        = 8'h00;
        mismatch_errors = 0;
        other_errors    = 0;
        checked         = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        if (rsp_valid !== 1'b0) begin
            mismatch_errors++;
            $display("[FAIL] rsp_valid: got %h expected %h", rsp_valid, 1'b0);
        end
        if (rsp.write_en !== 1'b0) begin
            mismatch_errors++;
            $display("[FAIL] rsp.write_en: got %h expected %h", rsp.write_en, 1'b0);
        end
        if (f !== 8'h00) begin
            mismatch_errors++;
            $display("[FAIL] f: got %h expected %h", f, 8'h00);
        end

        load_flags(8'h00);
        send_req(z80_pkg::ALU_ADD, 1'b0, 16'h007f, 16'h0001);   // signed overflow
        load_flags(8'h29);
        send_req(z80_pkg::ALU_SBC, 1'b0, 16'h0000, 16'h0000);   // borrow from F.C
        for (i = 0; i < N_ARITH8; i++) begin
            load_flags(rand8());
            idx = rand_below(5);
            send_req(z80_pkg::alu_func_e'(4'(idx < 4 ? idx : 7)), 1'b0, rand16(), rand16());
        end

        load_flags(rand8());
        for (i = 0; i < N_LOGIC8; i++) begin
            send_req(z80_pkg::alu_func_e'(4'(4 + rand_below(3))), 1'b0, rand16(), rand16());
        end

        for (k = 0; k < 8; k++) begin
            for (i = 0; i < N_ROT_EACH; i++) begin
                load_flags(rand8());    // random carry for rl and rr
                send_req(z80_pkg::alu_func_e'(4'(8 + k)), 1'b0, rand16(), rand16());
            end
        end

        load_flags(8'h00);
        send_req(z80_pkg::ALU_ADD, 1'b1, 16'h7fff, 16'h0001);
        send_req(z80_pkg::ALU_SUB, 1'b1, 16'h1000, 16'h0001);   // borrow across bit 11
        for (i = 0; i < N_ARITH16; i++) begin
            load_flags(rand8());
            idx = rand_below(5);
            send_req(z80_pkg::alu_func_e'(4'(idx < 4 ? idx : 7)), 1'b1, rand16(), rand16());
        end
        load_flags(rand8());
        for (i = 0; i < N_OTHER16; i++) begin
            idx = rand_below(11);
            send_req(z80_pkg::alu_func_e'(4'(idx < 3 ? 4 + idx : 5 + idx)), 1'b1,
                     rand16(), rand16());
        end

        load_flags(rand8());
        for (i = 0; i < N_BURST; i++) begin
            send_req(z80_pkg::alu_func_e'(4'(rand_below(16))), rand_below(2) == 1,
                     rand16(), rand16());
        end

        idle(4);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        other_errors += u_z80_alu_unit.u_sva.fail_count;
        $display("checked %0d responses: %0d value mismatches, %0d other errors",
                 checked, mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/z80_alu_unit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module z80_alu_unit_sva (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input logic f_load,
    input logic rsp_valid,
    input logic write_en
);

    int fail_count = 0;

    // response shows one cycle after the request is registered
    assert property (@(posedge clk) disable iff (reset) req_valid |-> ##2 rsp_valid)
    else begin
        fail_count++;
        $error("rsp_valid did not follow req_valid");
    end

    assert property (@(posedge clk) disable iff (reset) rsp_valid |-> $past(req_valid, 2))
    else begin
        fail_count++;
        $error("rsp_valid without a matching request");
    end

    assert property (@(posedge clk) !(req_valid && f_load))
    else begin
        fail_count++;
        $error("req_valid and f_load high together");
    end

    assert property (@(posedge clk) reset |=> (!rsp_valid && !write_en))
    else begin
        fail_count++;
        $error("rsp_valid or write_en high during reset");
    end

endmodule

bind z80_alu_unit z80_alu_unit_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .f_load    (f_load),
    .rsp_valid (rsp_valid),
    .write_en  (rsp.write_en)
);

`default_nettype wire

//--- hw/z80_alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module z80_alu_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  logic              f_load,
    input  z80_pkg::alu_req_t req,
    input  logic [7:0]        f_load_value,
    output logic              rsp_valid,
    output z80_pkg::alu_rsp_t rsp,
    output logic [7:0]        f
);

    logic [15:0]        alu_x;
    logic [15:0]        alu_y;
    z80_pkg::alu_func_e alu_func;
    logic [7:0]         alu_f_in;
    logic [7:0]         alu8_out;
    logic [7:0]         alu8_f;
    logic [15:0]        alu16_out;
    logic [7:0]         alu16_f;

    z80_alu_stage u_stage (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .f_load       (f_load),
        .req          (req),
        .f_load_value (f_load_value),
        .alu_x        (alu_x),
        .alu_y        (alu_y),
        .alu_func     (alu_func),
        .alu_f_in     (alu_f_in),
        .alu8_out     (alu8_out),
        .alu8_f       (alu8_f),
        .alu16_out    (alu16_out),
        .alu16_f      (alu16_f),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .f            (f)
    );

    // low bytes only on the 8-bit side
    z80_alu8 u_alu8 (
        .x    (alu_x[7:0]),
        .y    (alu_y[7:0]),
        .func (alu_func),
        .f_in (alu_f_in),
        .out  (alu8_out),
        .f    (alu8_f)
    );

    z80_alu16 u_alu16 (
        .x    (alu_x),
        .y    (alu_y),
        .func (alu_func),
        .f_in (alu_f_in),
        .out  (alu16_out),
        .f    (alu16_f)
    );

endmodule

`default_nettype wire

//--- hw/z80_alu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module z80_alu_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  logic               f_load,
    input  z80_pkg::alu_req_t  req,
    input  logic [7:0]         f_load_value,
    output logic [15:0]        alu_x,
    output logic [15:0]        alu_y,
    output z80_pkg::alu_func_e alu_func,
    output logic [7:0]         alu_f_in,
    input  logic [7:0]         alu8_out,
    input  logic [7:0]         alu8_f,
    input  logic [15:0]        alu16_out,
    input  logic [7:0]         alu16_f,
    output logic               rsp_valid,
    output z80_pkg::alu_rsp_t  rsp,
    output logic [7:0]         f
);

    z80_pkg::alu_req_t req_q;
    logic              req_pending;  // req_q holds a live request
    logic [7:0]        f_q;
    logic [15:0]       sel_out;
    logic [7:0]        sel_f;
    logic              rsp_valid_q;
    logic              write_en_q;
    logic [15:0]       result_q;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_pending <= 1'b0;
        end else begin
            req_pending <= req_valid;
        end
    end

    // both ALUs see the same operands
    assign alu_x    = req_q.x;
    assign alu_y    = req_q.y;
    assign alu_func = req_q.func;
    assign alu_f_in = f_q;

    assign sel_out = req_q.wide ? alu16_out : {8'h00, alu8_out};
    assign sel_f   = req_q.wide ? alu16_f : alu8_f;

    always_ff @(posedge clk) begin
        if (reset) begin
            f_q <= 8'h00;
        end else if (f_load && !req_valid) begin
            f_q <= f_load_value;             // load wins over the flag update
        end else if (req_pending) begin
            f_q <= sel_f;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
            write_en_q  <= 1'b0;
        end else begin
            rsp_valid_q <= req_pending;
            write_en_q  <= req_pending && (req_q.func != z80_pkg::ALU_CP);  // cp only flags
        end
    end

    always_ff @(posedge clk) begin
        if (req_pending) begin
            result_q <= sel_out;
        end
    end

    assign rsp_valid    = rsp_valid_q;
    assign rsp.result   = result_q;
    assign rsp.write_en = write_en_q;
    assign f            = f_q;

endmodule

`default_nettype wire

//--- hw/z80_alu16.sv
`timescale 1ns/1ps
`default_nettype none

// arithmetic only with H out of bit 11
module z80_alu16 (
    input  logic [15:0]        x,
    input  logic [15:0]        y,
    input  z80_pkg::alu_func_e func,
    input  logic [7:0]         f_in,
    output logic [15:0]        out,
    output logic [7:0]         f
);

    logic        carry;
    logic [15:0] add_out;
    logic [7:0]  add_f;
    logic [15:0] adc_out;
    logic [7:0]  adc_f;
    logic [15:0] sub_out;
    logic [7:0]  sub_f;
    logic [15:0] sbc_out;
    logic [7:0]  sbc_f;
    logic [7:0]  f_raw;

    assign carry = f_in[z80_pkg::FLAG_C];

    z80_adder #(.WIDTH(16)) u_add (
        .x(x), .y(y), .carry_in(1'b0), .sub_y(1'b0), .sum(add_out), .f(add_f)
    );

    z80_adder #(.WIDTH(16)) u_adc (
        .x(x), .y(y), .carry_in(carry), .sub_y(1'b0), .sum(adc_out), .f(adc_f)
    );

    z80_adder #(.WIDTH(16)) u_sub (
        .x(x), .y(~y), .carry_in(1'b1), .sub_y(1'b1), .sum(sub_out), .f(sub_f)
    );

    z80_adder #(.WIDTH(16)) u_sbc (
        .x(x), .y(~y), .carry_in(~carry), .sub_y(1'b1), .sum(sbc_out), .f(sbc_f)
    );

    always_comb begin
        case (func)
            z80_pkg::ALU_ADD: begin
                out   = add_out;
                f_raw = add_f;
            end
            z80_pkg::ALU_ADC: begin
                out   = adc_out;
                f_raw = adc_f;
            end
            z80_pkg::ALU_SUB, z80_pkg::ALU_CP: begin
                out   = sub_out;
                f_raw = sub_f;
            end
            z80_pkg::ALU_SBC: begin
                out   = sbc_out;
                f_raw = sbc_f;
            end
            default: begin                // no 16-bit logic or shifts
                out   = '0;
                f_raw = f_in;
            end
        endcase
    end

    assign f = (f_raw & ~z80_pkg::FLAG_KEEP_MASK) | (f_in & z80_pkg::FLAG_KEEP_MASK);

endmodule

`default_nettype wire

//--- hw/z80_alu8.sv
`timescale 1ns/1ps
`default_nettype none

module z80_alu8 (
    input  logic [7:0]         x,
    input  logic [7:0]         y,
    input  z80_pkg::alu_func_e func,
    input  logic [7:0]         f_in,
    output logic [7:0]         out,
    output logic [7:0]         f
);

    // sign, zero, parity flags shared by logic ops and shifts
    function automatic logic [7:0] szp_flags(input logic [7:0] v, input logic h,
                                             input logic c);
        logic [7:0] r;
        r = '0;
        r[z80_pkg::FLAG_S]  = v[7];
        r[z80_pkg::FLAG_Z]  = (v == 8'h00);
        r[z80_pkg::FLAG_H]  = h;
        r[z80_pkg::FLAG_PV] = ~^v;  // set on even parity
        r[z80_pkg::FLAG_C]  = c;
        return r;
    endfunction

    logic       carry;
    logic [7:0] add_out;
    logic [7:0] add_f;
    logic [7:0] adc_out;
    logic [7:0] adc_f;
    logic [7:0] sub_out;
    logic [7:0] sub_f;
    logic [7:0] sbc_out;
    logic [7:0] sbc_f;
    logic [7:0] logic_out;
    logic       rot_right;
    logic       rot_fill;  // bit entering the vacated end
    logic [7:0] rot_out;
    logic       rot_c;
    logic [7:0] f_raw;

    assign carry = f_in[z80_pkg::FLAG_C];

    z80_adder #(.WIDTH(8)) u_add (
        .x(x), .y(y), .carry_in(1'b0), .sub_y(1'b0), .sum(add_out), .f(add_f)
    );

    z80_adder #(.WIDTH(8)) u_adc (
        .x(x), .y(y), .carry_in(carry), .sub_y(1'b0), .sum(adc_out), .f(adc_f)
    );

    // x - y as x + ~y + 1
    z80_adder #(.WIDTH(8)) u_sub (
        .x(x), .y(~y), .carry_in(1'b1), .sub_y(1'b1), .sum(sub_out), .f(sub_f)
    );

    // x - y - c as x + ~y + ~c
    z80_adder #(.WIDTH(8)) u_sbc (
        .x(x), .y(~y), .carry_in(~carry), .sub_y(1'b1), .sum(sbc_out), .f(sbc_f)
    );

    always_comb begin
        case (func)
            z80_pkg::ALU_AND: logic_out = x & y;
            z80_pkg::ALU_XOR: logic_out = x ^ y;
            default:          logic_out = x | y;
        endcase
    end

    assign rot_right = (func == z80_pkg::ALU_RRC) || (func == z80_pkg::ALU_RR)
                    || (func == z80_pkg::ALU_SRA) || (func == z80_pkg::ALU_SRL);

    always_comb begin
        case (func)
            z80_pkg::ALU_RLC: rot_fill = x[7];
            z80_pkg::ALU_RRC: rot_fill = x[0];
            z80_pkg::ALU_RL:  rot_fill = carry;   // through carry
            z80_pkg::ALU_RR:  rot_fill = carry;
            z80_pkg::ALU_SRA: rot_fill = x[7];    // keep the sign
            z80_pkg::ALU_SLL: rot_fill = 1'b1;
            default:          rot_fill = 1'b0;    // sla, srl
        endcase
    end

    assign rot_out = rot_right ? {rot_fill, x[7:1]} : {x[6:0], rot_fill};
    assign rot_c   = rot_right ? x[0] : x[7];     // bit pushed off the end

    always_comb begin
        case (func)
            z80_pkg::ALU_ADD: begin
                out   = add_out;
                f_raw = add_f;
            end
            z80_pkg::ALU_ADC: begin
                out   = adc_out;
                f_raw = adc_f;
            end
            z80_pkg::ALU_SUB, z80_pkg::ALU_CP: begin
                out   = sub_out;
                f_raw = sub_f;
            end
            z80_pkg::ALU_SBC: begin
                out   = sbc_out;
                f_raw = sbc_f;
            end
            z80_pkg::ALU_AND, z80_pkg::ALU_XOR, z80_pkg::ALU_OR: begin
                out   = logic_out;
                f_raw = szp_flags(logic_out, func == z80_pkg::ALU_AND, 1'b0);
            end
            default: begin                        // rotates and shifts
                out   = rot_out;
                f_raw = szp_flags(rot_out, 1'b0, rot_c);
            end
        endcase
    end

    assign f = (f_raw & ~z80_pkg::FLAG_KEEP_MASK) | (f_in & z80_pkg::FLAG_KEEP_MASK);

endmodule

`default_nettype wire

//--- hw/z80_adder.sv
`timescale 1ns/1ps
`default_nettype none

// carry_in and an inverted y turn this into the Z80 subtractor
module z80_adder #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] x,
    input  logic [WIDTH-1:0] y,
    input  logic             carry_in,
    input  logic             sub_y,
    output logic [WIDTH-1:0] sum,
    output logic [7:0]       f
);

    logic [WIDTH-4:0] lo;           // low slice plus half carry
    logic [3:0]       mid;          // three bits below the msb
    logic [1:0]       top;          // msb and final carry
    logic             half_carry;
    logic             penult_carry;
    logic             carry_out;

    assign lo = {1'b0, x[WIDTH-5:0]} + {1'b0, y[WIDTH-5:0]}
              + {{(WIDTH-4){1'b0}}, carry_in};
    assign half_carry = lo[WIDTH-4];

    assign mid = {1'b0, x[WIDTH-2:WIDTH-4]} + {1'b0, y[WIDTH-2:WIDTH-4]}
               + {3'b000, half_carry};
    assign penult_carry = mid[3];   // carry into the sign bit

    assign top = {1'b0, x[WIDTH-1]} + {1'b0, y[WIDTH-1]} + {1'b0, penult_carry};
    assign carry_out = top[1];

    assign sum = {top[0], mid[2:0], lo[WIDTH-5:0]};

    always_comb begin
        f = '0;                     // bits 5 and 3 stay zero here
        f[z80_pkg::FLAG_S]  = sum[WIDTH-1];
        f[z80_pkg::FLAG_Z]  = (sum == '0);
        f[z80_pkg::FLAG_H]  = half_carry ^ sub_y;        // half borrow when subtracting
        f[z80_pkg::FLAG_PV] = carry_out ^ penult_carry;  // signed overflow
        f[z80_pkg::FLAG_N]  = sub_y;
        f[z80_pkg::FLAG_C]  = carry_out ^ sub_y;         // borrow when subtracting
    end

endmodule

`default_nettype wire

//--- hw/z80_pkg.sv
`default_nettype none

package z80_pkg;

    // function codes shared by both ALUs and the stage
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_ADC = 4'd1,
        ALU_SUB = 4'd2,
        ALU_SBC = 4'd3,
        ALU_AND = 4'd4,
        ALU_XOR = 4'd5,
        ALU_OR  = 4'd6,
        ALU_CP  = 4'd7,
        ALU_RLC = 4'd8,
        ALU_RRC = 4'd9,
        ALU_RL  = 4'd10,
        ALU_RR  = 4'd11,
        ALU_SLA = 4'd12,
        ALU_SRA = 4'd13,
        ALU_SLL = 4'd14,
        ALU_SRL = 4'd15
    } alu_func_e;

    // bit positions inside F
    localparam int FLAG_C  = 0;
    localparam int FLAG_N  = 1;
    localparam int FLAG_PV = 2;
    localparam int FLAG_3  = 3;
    localparam int FLAG_H  = 4;
    localparam int FLAG_5  = 5;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_S  = 7;

    // undocumented bits carried over from the old F
    localparam logic [7:0] FLAG_KEEP_MASK = (8'h01 << FLAG_5) | (8'h01 << FLAG_3);

    typedef struct packed {
        alu_func_e   func;
        logic        wide;      // 1 selects the 16-bit ALU
        logic [15:0] x;
        logic [15:0] y;
    } alu_req_t;

    typedef struct packed {
        logic [15:0] result;    // upper byte zero on 8-bit ops
        logic        write_en;
    } alu_rsp_t;

endpackage

`default_nettype wire
